/* design/core_settings.svh */
/* Widths, reset address and microcode depth for the toy core.
   NUM_REGS must equal 2**REG_SEL_W, and opcodes always take the top 4 bits of a word. */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// data, register and word address width
`define CORE_DATA_W 16

// first opcode fetch after reset
`define CORE_RESET_IP 16'h0000

// microcode rom depth is 2**MICRO_ADDR_W
`define MICRO_ADDR_W 4

// register file
`define NUM_REGS 4
`define REG_SEL_W 2

`endif

/* design/core_pkg.sv */
/* Shared types of the toy core. Opcodes 8 to 15 are undefined and decode as HLT.
   The microcode entry points here must match the table in micro_rom. */
`include "core_settings.svh"

package core_pkg;

  // top nibble of the opcode word
  typedef enum logic [3:0] {
    OP_HLT  = 4'h0,
    OP_MOVI = 4'h1,
    OP_ADD  = 4'h2,
    OP_SUB  = 4'h3,
    OP_XOR  = 4'h4,
    OP_LD   = 4'h5,
    OP_ST   = 4'h6,
    OP_JZ   = 4'h7
  } opcode_t;

  typedef enum logic [1:0] {
    FETCH_OP,
    FETCH_IMM,
    EXEC,
    HALT
  } fetch_state_t;

  typedef enum logic [1:0] {
    ALU_PASS,
    ALU_ADD,
    ALU_SUB,
    ALU_XOR
  } alu_op_t;

  // one control word of the microcode rom
  typedef struct packed {
    alu_op_t alu_op;
    logic    src_imm;
    logic    reg_we;
    logic    mem_rd;
    logic    mem_wr;
    logic    jmp_z;
    logic    end_seq;
  } micro_word_t;

  // microcode entry points, one per instruction
  localparam logic [`MICRO_ADDR_W-1:0] UA_HLT  = 0;
  localparam logic [`MICRO_ADDR_W-1:0] UA_MOVI = 1;
  localparam logic [`MICRO_ADDR_W-1:0] UA_ADD  = 2;
  localparam logic [`MICRO_ADDR_W-1:0] UA_SUB  = 3;
  localparam logic [`MICRO_ADDR_W-1:0] UA_XOR  = 4;
  localparam logic [`MICRO_ADDR_W-1:0] UA_LD   = 5;
  localparam logic [`MICRO_ADDR_W-1:0] UA_ST   = 6;
  localparam logic [`MICRO_ADDR_W-1:0] UA_JZ   = 7;

endpackage

/* design/core_fetch.sv */
/* Opcode and immediate fetch over the shared bus, one word per completed transfer.
   No request is issued while rst_i is high. HALT is left only by reset. */
`timescale 1ns/1ps
`include "core_settings.svh"

module core_fetch (
  input  logic                    clk,
  input  logic                    rst_i,
  input  logic                    bus_done_i,
  input  logic [`CORE_DATA_W-1:0] mem_dat_i,
  input  logic                    need_imm_i,
  input  logic                    is_halt_i,
  input  logic                    seq_end_i,
  output logic                    fetch_req_o,
  output logic                    ip_inc_o,
  output logic [`CORE_DATA_W-1:0] op_word_o,
  output logic [`CORE_DATA_W-1:0] imm_o,
  output logic                    seq_start_o,
  output logic                    exec_st_o,
  output logic                    halted_o
);

  core_pkg::fetch_state_t state_q;
  core_pkg::fetch_state_t state_d;
  logic [`CORE_DATA_W-1:0] op_q;
  logic [`CORE_DATA_W-1:0] imm_q;
  logic                    fetch_done;

  // bus read at ip in both fetch states, held off during reset
  assign fetch_req_o = !rst_i &&
                       (state_q == core_pkg::FETCH_OP || state_q == core_pkg::FETCH_IMM);
  assign fetch_done  = fetch_req_o && bus_done_i;
  assign ip_inc_o    = fetch_done;

  // decode sees the word on the bus while the opcode is still being read
  assign op_word_o = (state_q == core_pkg::FETCH_OP) ? mem_dat_i : op_q;
  assign imm_o     = imm_q;

  // sequencer starts on the last fetched word of the instruction
  assign seq_start_o = fetch_done && (state_q == core_pkg::FETCH_IMM || !need_imm_i);
  assign exec_st_o   = (state_q == core_pkg::EXEC);
  assign halted_o    = (state_q == core_pkg::HALT);

  always_comb begin
    state_d = state_q;
    case (state_q)
      core_pkg::FETCH_OP: begin
        if (fetch_done) begin
          state_d = need_imm_i ? core_pkg::FETCH_IMM : core_pkg::EXEC;
        end
      end
      core_pkg::FETCH_IMM: begin
        if (fetch_done) begin
          state_d = core_pkg::EXEC;
        end
      end
      core_pkg::EXEC: begin
        // hlt runs its single end step before parking
        if (seq_end_i) begin
          state_d = is_halt_i ? core_pkg::HALT : core_pkg::FETCH_OP;
        end
      end
      default: state_d = core_pkg::HALT;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= core_pkg::FETCH_OP;
    end else begin
      state_q <= state_d;
    end
  end

  // opcode and immediate latches
  always_ff @(posedge clk) begin
    if (fetch_done && state_q == core_pkg::FETCH_OP) begin
      op_q <= mem_dat_i;
    end
    if (fetch_done && state_q == core_pkg::FETCH_IMM) begin
      imm_q <= mem_dat_i;
    end
  end

endmodule

/* design/core_decode.sv */
/* Opcode to microcode entry point, purely combinational.
   Word layout is opcode, dst, src from the top bit down. Unknown opcodes decode as HLT. */
`timescale 1ns/1ps
`include "core_settings.svh"

module core_decode (
  input  logic [`CORE_DATA_W-1:0]  op_word_i,
  output logic [`MICRO_ADDR_W-1:0] start_adr_o,
  output logic                     need_imm_o,
  output logic                     is_halt_o,
  output logic [`REG_SEL_W-1:0]    dst_o,
  output logic [`REG_SEL_W-1:0]    src_o
);

  core_pkg::opcode_t opcode;

  assign opcode = core_pkg::opcode_t'(op_word_i[`CORE_DATA_W-1 -: 4]);

  // register fields right below the opcode
  assign dst_o = op_word_i[`CORE_DATA_W-5 -: `REG_SEL_W];
  assign src_o = op_word_i[`CORE_DATA_W-5-`REG_SEL_W -: `REG_SEL_W];

  always_comb begin
    start_adr_o = core_pkg::UA_HLT;
    need_imm_o  = 1'b0;
    is_halt_o   = 1'b0;
    case (opcode)
      core_pkg::OP_MOVI: begin
        start_adr_o = core_pkg::UA_MOVI;
        need_imm_o  = 1'b1;
      end
      core_pkg::OP_ADD: start_adr_o = core_pkg::UA_ADD;
      core_pkg::OP_SUB: start_adr_o = core_pkg::UA_SUB;
      core_pkg::OP_XOR: start_adr_o = core_pkg::UA_XOR;
      // ld, st and jz carry an address word
      core_pkg::OP_LD: begin
        start_adr_o = core_pkg::UA_LD;
        need_imm_o  = 1'b1;
      end
      core_pkg::OP_ST: begin
        start_adr_o = core_pkg::UA_ST;
        need_imm_o  = 1'b1;
      end
      core_pkg::OP_JZ: begin
        start_adr_o = core_pkg::UA_JZ;
        need_imm_o  = 1'b1;
      end
      default: is_halt_o = 1'b1;
    endcase
  end

endmodule

/* design/micro_seq.sv */
/* Micro program counter. Steps only between seq_start_i and the end step,
   and a memory step waits for its bus transfer. Address rests at zero when idle. */
`timescale 1ns/1ps
`include "core_settings.svh"

module micro_seq (
  input  logic                     clk,
  input  logic                     rst_i,
  input  logic                     seq_start_i,
  input  logic [`MICRO_ADDR_W-1:0] start_adr_i,
  input  core_pkg::micro_word_t    uword_i,
  input  logic                     bus_done_i,
  output logic [`MICRO_ADDR_W-1:0] micro_adr_o,
  output logic                     step_done_o,
  output logic                     seq_end_o
);

  logic [`MICRO_ADDR_W-1:0] adr_q;
  logic                     busy_q;
  logic                     mem_step;

  assign mem_step    = uword_i.mem_rd || uword_i.mem_wr;
  // stalled bus step holds the address
  assign step_done_o = busy_q && (!mem_step || bus_done_i);
  assign seq_end_o   = step_done_o && uword_i.end_seq;
  assign micro_adr_o = adr_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      adr_q  <= '0;
      busy_q <= 1'b0;
    end else if (seq_start_i) begin
      adr_q  <= start_adr_i;
      busy_q <= 1'b1;
    end else if (seq_end_o) begin
      adr_q  <= '0;
      busy_q <= 1'b0;
    end else if (step_done_o) begin
      adr_q <= adr_q + 1'b1;
    end
  end

endmodule

/* design/micro_rom.sv */
/* Constant microcode table, one control word per instruction.
   Addresses outside the table return a bare end step. */
`timescale 1ns/1ps
`include "core_settings.svh"

module micro_rom (
  input  logic [`MICRO_ADDR_W-1:0] micro_adr_i,
  output core_pkg::micro_word_t    uword_o
);

  always_comb begin
    // every entry is a single step, so end_seq is on by default
    uword_o         = '0;
    uword_o.alu_op  = core_pkg::ALU_PASS;
    uword_o.end_seq = 1'b1;
    case (micro_adr_i)
      // immediate passes straight through the alu
      core_pkg::UA_MOVI: begin
        uword_o.src_imm = 1'b1;
        uword_o.reg_we  = 1'b1;
      end
      core_pkg::UA_ADD: begin
        uword_o.alu_op = core_pkg::ALU_ADD;
        uword_o.reg_we = 1'b1;
      end
      core_pkg::UA_SUB: begin
        uword_o.alu_op = core_pkg::ALU_SUB;
        uword_o.reg_we = 1'b1;
      end
      core_pkg::UA_XOR: begin
        uword_o.alu_op = core_pkg::ALU_XOR;
        uword_o.reg_we = 1'b1;
      end
      // load writes bus data, not the alu result
      core_pkg::UA_LD: begin
        uword_o.mem_rd = 1'b1;
        uword_o.reg_we = 1'b1;
      end
      core_pkg::UA_ST: begin
        uword_o.mem_wr = 1'b1;
      end
      core_pkg::UA_JZ: begin
        uword_o.jmp_z = 1'b1;
      end
      // hlt and spare entries
      default: uword_o.end_seq = 1'b1;
    endcase
  end

endmodule

/* design/core_exec.sv */
/* Register file, ALU, zero flag and instruction pointer. Registers are not cleared
   by reset, so a program writes them before reading. zf follows MOVI and ALU ops, not LD. */
`timescale 1ns/1ps
`include "core_settings.svh"

module core_exec (
  input  logic                    clk,
  input  logic                    rst_i,
  input  core_pkg::micro_word_t   uword_i,
  input  logic                    step_done_i,
  input  logic                    exec_st_i,
  input  logic [`REG_SEL_W-1:0]   dst_i,
  input  logic [`REG_SEL_W-1:0]   src_i,
  input  logic [`CORE_DATA_W-1:0] imm_i,
  input  logic                    ip_inc_i,
  input  logic [`CORE_DATA_W-1:0] mem_dat_i,
  output logic [`CORE_DATA_W-1:0] ip_o,
  output logic                    zf_o,
  output logic [`CORE_DATA_W-1:0] data_adr_o,
  output logic [`CORE_DATA_W-1:0] data_dat_o,
  output logic                    data_we_o,
  output logic                    data_req_o
);

  logic [`CORE_DATA_W-1:0] regs_q [`NUM_REGS];
  logic [`CORE_DATA_W-1:0] ip_q;
  logic                    zf_q;
  logic [`CORE_DATA_W-1:0] opa;
  logic [`CORE_DATA_W-1:0] opb;
  logic [`CORE_DATA_W-1:0] alu_res;
  logic [`CORE_DATA_W-1:0] wb_dat;
  logic                    alu_wr;

  // dst is also the first operand and the store data
  assign opa = regs_q[dst_i];
  assign opb = uword_i.src_imm ? imm_i : regs_q[src_i];

  always_comb begin
    case (uword_i.alu_op)
      core_pkg::ALU_ADD: alu_res = opa + opb;
      core_pkg::ALU_SUB: alu_res = opa - opb;
      core_pkg::ALU_XOR: alu_res = opa ^ opb;
      default:           alu_res = opb;
    endcase
  end

  assign wb_dat = uword_i.mem_rd ? mem_dat_i : alu_res;
  assign alu_wr = step_done_i && uword_i.reg_we && !uword_i.mem_rd;

  always_ff @(posedge clk) begin
    if (step_done_i && uword_i.reg_we) begin
      regs_q[dst_i] <= wb_dat;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ip_q <= `CORE_RESET_IP;
      zf_q <= 1'b0;
    end else begin
      // fetch and a jump never fall in the same cycle
      if (ip_inc_i) begin
        ip_q <= ip_q + 1'b1;
      end else if (step_done_i && uword_i.jmp_z && zf_q) begin
        ip_q <= imm_i;
      end
      if (alu_wr) begin
        zf_q <= (alu_res == '0);
      end
    end
  end

  assign ip_o = ip_q;
  assign zf_o = zf_q;

  // data side of the bus, address always from the immediate word
  assign data_req_o = exec_st_i && (uword_i.mem_rd || uword_i.mem_wr);
  assign data_we_o  = exec_st_i && uword_i.mem_wr;
  assign data_adr_o = imm_i;
  assign data_dat_o = opa;

endmodule

/* design/core_top.sv */
/* Toy microcoded core on one word-addressed bus with block_i back-pressure.
   A transfer completes when mem_req_o is high and block_i is low; read data is valid then. */
`timescale 1ns/1ps
`include "core_settings.svh"

module core_top (
  input  logic                    clk,
  input  logic                    rst_i,
  input  logic [`CORE_DATA_W-1:0] mem_dat_i,
  input  logic                    block_i,
  output logic [`CORE_DATA_W-1:0] mem_adr_o,
  output logic [`CORE_DATA_W-1:0] mem_dat_o,
  output logic                    mem_we_o,
  output logic                    mem_req_o,
  output logic                    halted_o,
  output logic [`CORE_DATA_W-1:0] pc_o
);

  logic                     bus_done;
  logic                     fetch_req;
  logic                     ip_inc;
  logic [`CORE_DATA_W-1:0]  op_word;
  logic [`CORE_DATA_W-1:0]  imm;
  logic                     seq_start;
  logic                     exec_st;
  logic [`MICRO_ADDR_W-1:0] start_adr;
  logic                     need_imm;
  logic                     is_halt;
  logic [`REG_SEL_W-1:0]    dst;
  logic [`REG_SEL_W-1:0]    src;
  logic [`MICRO_ADDR_W-1:0] micro_adr;
  core_pkg::micro_word_t    uword;
  logic                     step_done;
  logic                     seq_end;
  logic [`CORE_DATA_W-1:0]  ip;
  logic [`CORE_DATA_W-1:0]  data_adr;
  logic [`CORE_DATA_W-1:0]  data_dat;
  logic                     data_we;
  logic                     data_req;

  core_fetch u_fetch (
    .clk (clk), .rst_i (rst_i), .bus_done_i (bus_done), .mem_dat_i (mem_dat_i),
    .need_imm_i (need_imm), .is_halt_i (is_halt), .seq_end_i (seq_end),
    .fetch_req_o (fetch_req), .ip_inc_o (ip_inc), .op_word_o (op_word), .imm_o (imm),
    .seq_start_o (seq_start), .exec_st_o (exec_st), .halted_o (halted_o)
  );

  core_decode u_decode (
    .op_word_i (op_word), .start_adr_o (start_adr), .need_imm_o (need_imm),
    .is_halt_o (is_halt), .dst_o (dst), .src_o (src)
  );

  micro_seq u_seq (
    .clk (clk), .rst_i (rst_i), .seq_start_i (seq_start), .start_adr_i (start_adr),
    .uword_i (uword), .bus_done_i (bus_done), .micro_adr_o (micro_adr),
    .step_done_o (step_done), .seq_end_o (seq_end)
  );

  micro_rom u_rom (
    .micro_adr_i (micro_adr), .uword_o (uword)
  );

  core_exec u_exec (
    .clk (clk), .rst_i (rst_i), .uword_i (uword), .step_done_i (step_done),
    .exec_st_i (exec_st), .dst_i (dst), .src_i (src), .imm_i (imm), .ip_inc_i (ip_inc),
    .mem_dat_i (mem_dat_i), .ip_o (ip), .zf_o (), .data_adr_o (data_adr),
    .data_dat_o (data_dat), .data_we_o (data_we), .data_req_o (data_req)
  );

  // exec owns the bus only in EXEC, fetch otherwise
  assign mem_req_o = exec_st ? data_req : fetch_req;
  assign mem_adr_o = exec_st ? data_adr : ip;
  assign mem_dat_o = exec_st ? data_dat : '0;
  assign mem_we_o  = exec_st ? data_we : 1'b0;
  assign bus_done  = mem_req_o && !block_i;
  assign pc_o      = ip;

endmodule

/* bench/core_assertions.sv */
/* Bus protocol, reset and halt properties, bound into core_top.
   All sampled on the rising clock edge. */
`timescale 1ns/1ps
`include "core_settings.svh"

module core_assertions (
  input logic                    clk,
  input logic                    rst_i,
  input logic                    req_i,
  input logic                    we_i,
  input logic [`CORE_DATA_W-1:0] adr_i,
  input logic [`CORE_DATA_W-1:0] dat_i,
  input logic                    block_i,
  input logic                    halted_i
);

  int unsigned fail_cnt = 0;

  // bus quiet once reset has been seen for a full cycle
  a_reset_quiet: assert property (@(posedge clk) rst_i && $past(rst_i) |-> !req_i && !we_i)
    else begin
      fail_cnt++;
      $error("bus active during reset");
    end

  // first cycle out of reset reads the reset address
  a_first_fetch: assert property (@(posedge clk)
      $fell(rst_i) |-> req_i && !we_i && adr_i == `CORE_RESET_IP)
    else begin
      fail_cnt++;
      $error("first request after reset not a read at the reset address");
    end

  // stalled transfer keeps its address, data and direction
  a_block_hold: assert property (@(posedge clk) disable iff (rst_i)
      req_i && block_i |=> req_i && $stable(adr_i) && $stable(dat_i) && $stable(we_i))
    else begin
      fail_cnt++;
      $error("bus changed while blocked");
    end

  a_halt_sticky: assert property (@(posedge clk) disable iff (rst_i) halted_i |=> halted_i)
    else begin
      fail_cnt++;
      $error("halt left without reset");
    end

  a_halt_quiet: assert property (@(posedge clk) disable iff (rst_i) halted_i |-> !req_i)
    else begin
      fail_cnt++;
      $error("request raised while halted");
    end

endmodule

bind core_top core_assertions u_chk (
  .clk      (clk),
  .rst_i    (rst_i),
  .req_i    (mem_req_o),
  .we_i     (mem_we_o),
  .adr_i    (mem_adr_o),
  .dat_i    (mem_dat_o),
  .block_i  (block_i),
  .halted_i (halted_o)
);

/* bench/core_tb.sv */
/* Random program bench for core_top, seed 98363, with random block_i stalls.
   Memory is 512 words with code below 0x100 and data above. Registers are set by MOVI first. */
`timescale 1ns/1ps
`include "core_settings.svh"

module core_tb;

  localparam int MEM_WORDS = 512;
  localparam int BLOCKS    = 16;

  logic                    clk;
  logic                    rst_i;
  logic [`CORE_DATA_W-1:0] mem_dat_i;
  logic                    block_i;
  logic [`CORE_DATA_W-1:0] mem_adr_o;
  logic [`CORE_DATA_W-1:0] mem_dat_o;
  logic                    mem_we_o;
  logic                    mem_req_o;
  logic                    halted_o;
  logic [`CORE_DATA_W-1:0] pc_o;

  // dut memory and the image it starts from
  logic [`CORE_DATA_W-1:0] mem [MEM_WORDS];
  logic [`CORE_DATA_W-1:0] img [MEM_WORDS];
  // expected stores with the address in the upper half
  logic [31:0]             exp_q [$];
  logic [31:0]             exp_w;
  // ip expected once the core has halted
  logic [`CORE_DATA_W-1:0] end_pc;
  integer                  seed;
  int                      wp;
  int                      n_instr;
  int                      cycles;
  int                      limit;

  core_top dut (
    .clk       (clk),
    .rst_i     (rst_i),
    .mem_dat_i (mem_dat_i),
    .block_i   (block_i),
    .mem_adr_o (mem_adr_o),
    .mem_dat_o (mem_dat_o),
    .mem_we_o  (mem_we_o),
    .mem_req_o (mem_req_o),
    .halted_o  (halted_o),
    .pc_o      (pc_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // read data valid in the same cycle as the address
  assign mem_dat_i = mem[mem_adr_o[8:0]];

  function automatic int rnd(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // opcode, dst, src from the top bit down
  function automatic logic [`CORE_DATA_W-1:0] op_word(input logic [3:0] op,
                                                      input logic [1:0] d,
                                                      input logic [1:0] s);
    return {op, d, s, 8'h00};
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic show_mismatch(input string name, input logic [`CORE_DATA_W-1:0] got,
                               input logic [`CORE_DATA_W-1:0] want);
    stop_run($sformatf("mismatch %s: got %h, expected %h", name, got, want));
  endtask

  task automatic emit(input logic [`CORE_DATA_W-1:0] w);
    img[wp] = w;
    wp = wp + 1;
  endtask

  task automatic emit_store(input logic [1:0] d, inout logic [`CORE_DATA_W-1:0] adr);
    emit(op_word(core_pkg::OP_ST, d, 2'd0));
    emit(adr);
    adr = adr + 16'd1;
  endtask

  task automatic build_program();
    logic [`CORE_DATA_W-1:0] st_adr;
    logic [1:0]              d;
    logic [1:0]              s;
    logic [3:0]              alu;
    int                      a;
    st_adr = 16'h0180;
    wp = 0;
    // odd multiplier gives every address its own word
    for (a = 0; a < MEM_WORDS; a++) begin
      img[a] = 16'(a * 40503) ^ 16'h5a5a;
    end
    for (a = 0; a < 4; a++) begin
      emit(op_word(core_pkg::OP_MOVI, 2'(a), 2'd0));
      emit(16'(rnd(65536)));
    end
    // each block ends in a store so the result shows on the bus
    for (a = 0; a < BLOCKS; a++) begin
      d = 2'(rnd(4));
      s = 2'(rnd(4));
      case (rnd(4))
        0: begin
          case (rnd(3))
            0: alu = core_pkg::OP_ADD;
            1: alu = core_pkg::OP_SUB;
            default: alu = core_pkg::OP_XOR;
          endcase
          emit(op_word(alu, d, s));
        end
        1: begin
          emit(op_word(core_pkg::OP_MOVI, d, 2'd0));
          emit(16'(rnd(65536)));
        end
        2: begin
          // data window overlaps earlier stores
          emit(op_word(core_pkg::OP_LD, d, 2'd0));
          emit(16'(16'h0100 + rnd(192)));
        end
        default: begin
          // zero result jumps over the store
          if (rnd(2) == 0) begin
            emit(op_word(core_pkg::OP_XOR, d, d));
          end else begin
            emit(op_word(core_pkg::OP_MOVI, d, 2'd0));
            emit(16'(rnd(65536)) | 16'h0001);
          end
          emit(op_word(core_pkg::OP_JZ, 2'd0, 2'd0));
          emit(16'(wp + 3));
        end
      endcase
      emit_store(d, st_adr);
    end
    emit(op_word(core_pkg::OP_HLT, 2'd0, 2'd0));
  endtask

  // instruction level model of the ISA that fills exp_q
  task automatic run_model();
    logic [`CORE_DATA_W-1:0] r [4];
    logic [`CORE_DATA_W-1:0] mimg [MEM_WORDS];
    logic [`CORE_DATA_W-1:0] w;
    logic [`CORE_DATA_W-1:0] imm;
    logic [`CORE_DATA_W-1:0] pc;
    logic [1:0]              d;
    logic [1:0]              s;
    logic                    zf;
    logic                    done;
    mimg = img;
    pc = `CORE_RESET_IP;
    zf = 1'b0;
    done = 1'b0;
    n_instr = 0;
    while (!done && n_instr < 1000) begin
      w = mimg[pc[8:0]];
      d = w[11:10];
      s = w[9:8];
      pc = pc + 16'd1;
      imm = mimg[pc[8:0]];
      n_instr = n_instr + 1;
      case (w[15:12])
        core_pkg::OP_MOVI: begin
          pc = pc + 16'd1;
          r[d] = imm;
          zf = (imm == 16'd0);
        end
        core_pkg::OP_ADD: begin
          r[d] = r[d] + r[s];
          zf = (r[d] == 16'd0);
        end
        core_pkg::OP_SUB: begin
          r[d] = r[d] - r[s];
          zf = (r[d] == 16'd0);
        end
        core_pkg::OP_XOR: begin
          r[d] = r[d] ^ r[s];
          zf = (r[d] == 16'd0);
        end
        // load leaves the zero flag alone
        core_pkg::OP_LD: begin
          pc = pc + 16'd1;
          r[d] = mimg[imm[8:0]];
        end
        core_pkg::OP_ST: begin
          pc = pc + 16'd1;
          mimg[imm[8:0]] = r[d];
          exp_q.push_back({imm, r[d]});
        end
        core_pkg::OP_JZ: begin
          pc = pc + 16'd1;
          if (zf) begin
            pc = imm;
          end
        end
        default: done = 1'b1;
      endcase
    end
    // hlt is one word, so ip rests just past it
    end_pc = pc;
  endtask

  // about one stall in four
  always @(posedge clk) begin
    block_i <= (rnd(4) == 0);
  end

  // memory write and store check on a completed transfer
  always @(posedge clk) begin
    if (!rst_i && mem_req_o && mem_we_o && !block_i) begin
      mem[mem_adr_o[8:0]] <= mem_dat_o;
      if (exp_q.size() == 0) begin
        stop_run("store seen after the last expected one");
      end else begin
        exp_w = exp_q.pop_front();
        assert (mem_adr_o == exp_w[31:16])
          else show_mismatch("mem_adr_o", mem_adr_o, exp_w[31:16]);
        assert (mem_dat_o == exp_w[15:0])
          else show_mismatch("mem_dat_o", mem_dat_o, exp_w[15:0]);
      end
    end
  end

  always @(posedge clk) begin
    if (!rst_i) begin
      cycles <= cycles + 1;
      if (cycles > limit) begin
        stop_run("timeout, core did not halt in time");
      end
    end
  end

  always @(negedge clk) begin
    if (dut.u_chk.fail_cnt != 0) begin
      stop_run("bound assertion on bus, reset or halt failed");
    end
  end

  initial begin
    int a;
    seed = 98363;
    rst_i <= 1'b1;
    block_i <= 1'b0;
    cycles <= 0;
    build_program();
    for (a = 0; a < MEM_WORDS; a++) begin
      mem[a] <= img[a];
    end
    run_model();
    limit = n_instr * 40;
    repeat (2) @(posedge clk);
    rst_i <= 1'b0;
    while (!halted_o) @(posedge clk);
    repeat (10) @(posedge clk);
    assert (pc_o == end_pc)
      else show_mismatch("pc_o", pc_o, end_pc);
    if (exp_q.size() != 0) begin
      stop_run($sformatf("%0d expected stores never happened", exp_q.size()));
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

/* build.f */
+incdir+design
design/core_pkg.sv
design/core_fetch.sv
design/core_decode.sv
design/micro_seq.sv
design/micro_rom.sv
design/core_exec.sv
design/core_top.sv
bench/core_assertions.sv
bench/core_tb.sv

/* Makefile */
# Verilator build and run for the toy core bench

VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

SRCS    := $(shell grep -v '^+' $(FILELIST)) design/core_settings.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) | tee $(LOG)
	@grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
